/* Makefile */
# Verilator build and run of the panel frame buffer testbench
TOP = frameBufferTb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

# the run passes only if the testbench printed its pass line
test:
	verilator --binary -j 0 --assert --timescale 1ns/1ps \
		--top-module $(TOP) -Mdir obj_dir -f panelBuffer.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir

/* panelBuffer.f */
rtl/panelPkg.sv
rtl/laneMemory.sv
rtl/laneBank.sv
rtl/pixelWriter.sv
rtl/scanReader.sv
rtl/frameBuffer.sv
test/frameBufferTb.sv

/* rtl/frameBuffer.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// panel frame buffer top: byte-wide write handshake
// in, 64-bit lane word read handshake out
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module frameBuffer (
    input  logic                               ClockA,
    input  logic                               rstN,
    // write side
    input  logic                               wrReq,
    output logic                               wrAck,
    input  logic [panelPkg::numWrAddrBits-1:0] wrAddr,
    input  logic [panelPkg::dataBits-1:0]      wrData,
    // read side
    input  logic                               rdReq,
    output logic                               rdAck,
    input  logic [panelPkg::numBodyBits-1:0]   rdAddr,
    output logic [panelPkg::laneWordBits-1:0]  rdData
);
    import panelPkg::*;

    // writer to bank
    logic                     writeStrobe;
    logic [numWrAddrBits-1:0] writeAddr;
    logic [dataBits-1:0]      writeData;

    // reader to bank and back
    logic                    fetchEnable;
    logic [numBodyBits-1:0]  fetchAddr;
    logic [laneWordBits-1:0] laneWord;

    pixelWriter writerInst (
        .ClockA     (ClockA),
        .rstN       (rstN),
        .wrReq      (wrReq),
        .wrAddr     (wrAddr),
        .wrData     (wrData),
        .wrAck      (wrAck),
        .writeStrobe(writeStrobe),
        .writeAddr  (writeAddr),
        .writeData  (writeData)
    );

    // the two sides meet only here, in the lane RAMs
    laneBank bankInst (
        .ClockA     (ClockA),
        .rstN       (rstN),
        .writeStrobe(writeStrobe),
        .writeAddr  (writeAddr),
        .writeData  (writeData),
        .fetchEnable(fetchEnable),
        .fetchAddr  (fetchAddr),
        .laneWord   (laneWord)
    );

    scanReader readerInst (
        .ClockA     (ClockA),
        .rstN       (rstN),
        .rdReq      (rdReq),
        .rdAddr     (rdAddr),
        .laneWord   (laneWord),
        .rdAck      (rdAck),
        .rdData     (rdData),
        .fetchEnable(fetchEnable),
        .fetchAddr  (fetchAddr)
    );

endmodule

/* rtl/laneBank.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// eight-lane pixel store; decodes the lane from the
// write address and reads all lanes as one wide word
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module laneBank (
    input  logic                               ClockA,
    input  logic                               rstN,
    input  logic                               writeStrobe,
    input  logic [panelPkg::numWrAddrBits-1:0] writeAddr,
    input  logic [panelPkg::dataBits-1:0]      writeData,
    input  logic                               fetchEnable,
    input  logic [panelPkg::numBodyBits-1:0]   fetchAddr,
    output logic [panelPkg::laneWordBits-1:0]  laneWord
);
    import panelPkg::*;

    // decoded write address fields
    logic [numLaneBits-1:0] laneSel;
    logic [numBodyBits-1:0] bodyAddr;

    // registered write enables of all lanes, gathered for the check below
    logic [numLanes-1:0] laneWe;

    // subpanel is the top field, colour select the bottom one
    assign laneSel = {writeAddr[numWrAddrBits-1 -: numSubpanelBits],
                      writeAddr[numColorSelBits-1:0]};

    // body sits between them and becomes the lane word address
    assign bodyAddr = writeAddr[numColorSelBits +: numBodyBits];

    genvar lane;
    generate
        for (lane = 0; lane < numLanes; lane = lane + 1) begin : laneGen
            // per-lane write register, one cycle in front of the RAM
            logic                   weQ;
            logic [numBodyBits-1:0] addrQ;
            logic [dataBits-1:0]    dataQ;

            always_ff @(posedge ClockA or negedge rstN) begin
                if (!rstN) begin
                    weQ <= 1'b0;
                end else begin
                    weQ <= writeStrobe && (laneSel == numLaneBits'(lane));
                end
            end

            // address and data follow every cycle, only weQ qualifies them
            always_ff @(posedge ClockA) begin
                addrQ <= bodyAddr;
                dataQ <= writeData;
            end

            assign laneWe[lane] = weQ;

            // all lanes share the read side
            laneMemory #(
                .addrBits(numBodyBits),
                .dataBits(dataBits)
            ) memInst (
                .ClockA     (ClockA),
                .rstN       (rstN),
                .writeEnable(weQ),
                .writeAddr  (addrQ),
                .writeData  (dataQ),
                .readEnable (fetchEnable),
                .readAddr   (fetchAddr),
                .readData   (laneWord[lane*dataBits +: dataBits])
            );
        end
    endgenerate

    // a strobe must land in exactly one lane, never spill into a neighbour
    oneLaneWrite: assert property (@(posedge ClockA) disable iff (!rstN)
        $onehot0(laneWe))
        else $error("laneBank: more than one lane written at once");

endmodule

/* rtl/laneMemory.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// simple dual-port RAM for one lane with synchronous
// write and a registered read port sized by its parameters
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module laneMemory #(
    parameter int unsigned addrBits = 5,
    parameter int unsigned dataBits = 8
) (
    input  logic                ClockA,
    input  logic                rstN,
    input  logic                writeEnable,
    input  logic [addrBits-1:0] writeAddr,
    input  logic [dataBits-1:0] writeData,
    input  logic                readEnable,
    input  logic [addrBits-1:0] readAddr,
    output logic [dataBits-1:0] readData
);

    localparam int unsigned depth = 1 << addrBits;

    // storage array with contents undefined until written
    logic [dataBits-1:0] mem [0:depth-1];

    // write port
    always_ff @(posedge ClockA) begin
        if (writeEnable) begin
            mem[writeAddr] <= writeData;
        end
    end

    // read port
    // output register loads only on a fetch and holds otherwise
    always_ff @(posedge ClockA or negedge rstN) begin
        if (!rstN) begin
            readData <= '0;
        end else if (readEnable) begin
            readData <= mem[readAddr];
        end
    end

    // a read on the same edge as a write to that address returns the old word
    // a read requested after wrAck has fallen already sees the new byte

endmodule

/* rtl/panelPkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared widths and FSM state types for the panel
// frame buffer, imported by each RTL module
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package panelPkg;

    // write address layout, msb first: subpanel, body, colour select
    localparam int unsigned numSubpanelBits = 1;
    localparam int unsigned numColorSelBits = 2;
    localparam int unsigned numBodyBits = 5;

    // full byte address seen on the write port
    localparam int unsigned numWrAddrBits = numSubpanelBits + numBodyBits + numColorSelBits;

    // lane index is the subpanel bit followed by the colour-select bits
    localparam int unsigned numLaneBits = numSubpanelBits + numColorSelBits;
    localparam int unsigned numLanes = 1 << numLaneBits;

    // one pixel byte, also the word width of one lane
    localparam int unsigned dataBits = 8;

    // read side returns every lane side by side
    // lane 0 sits in the low byte
    localparam int unsigned laneWordBits = numLanes * dataBits;

    // input side FSM
    // wrAck state covers the whole acknowledge phase
    typedef enum logic {
        wrIdle = 1'b0,
        wrAck  = 1'b1
    } writerState;

    // output side FSM
    // rdFetch spans the RAM read and the capture cycle
    typedef enum logic [1:0] {
        rdIdle  = 2'd0,
        rdFetch = 2'd1,
        rdHold  = 2'd2
    } readerState;

endpackage

/* rtl/pixelWriter.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// write port front end, turns each four-phase
// request into a single strobe toward the lane bank
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module pixelWriter (
    input  logic                               ClockA,
    input  logic                               rstN,
    input  logic                               wrReq,
    input  logic [panelPkg::numWrAddrBits-1:0] wrAddr,
    input  logic [panelPkg::dataBits-1:0]      wrData,
    output logic                               wrAck,
    output logic                               writeStrobe,
    output logic [panelPkg::numWrAddrBits-1:0] writeAddr,
    output logic [panelPkg::dataBits-1:0]      writeData
);
    import panelPkg::*;

    // the wrAck port hides the state literal of the same name,
    // so the state is referred to with its package scope below
    writerState state;

    // control side: state, strobe and acknowledge
    always_ff @(posedge ClockA or negedge rstN) begin
        if (!rstN) begin
            state       <= wrIdle;
            writeStrobe <= 1'b0;
            wrAck       <= 1'b0;
        end else begin
            // strobe lasts exactly the cycle after capture
            writeStrobe <= 1'b0;
            case (state)
                wrIdle: begin
                    if (wrReq) begin
                        writeStrobe <= 1'b1;
                        state       <= panelPkg::wrAck;
                    end
                end
                panelPkg::wrAck: begin
                    // ack rises one edge after capture and follows wrReq down
                    wrAck <= wrReq;
                    if (!wrReq) begin
                        state <= wrIdle;
                    end
                end
                default: begin
                    state <= wrIdle;
                    wrAck <= 1'b0;
                end
            endcase
        end
    end

    // payload side
    // address and data are taken once, on the capture edge
    always_ff @(posedge ClockA) begin
        if (state == wrIdle && wrReq) begin
            writeAddr <= wrAddr;
            writeData <= wrData;
        end
    end

    // one request gives one strobe, never a two-cycle write
    strobeSingle: assert property (@(posedge ClockA) disable iff (!rstN)
        writeStrobe |=> !writeStrobe)
        else $error("pixelWriter: writeStrobe held for two cycles");

    // ack and FSM must agree on the handshake phase
    ackNotIdle: assert property (@(posedge ClockA) disable iff (!rstN)
        state == wrIdle |-> !wrAck)
        else $error("pixelWriter: wrAck high while idle");

endmodule

/* rtl/scanReader.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// read port front end; one four-phase request
// fetches a full 64-bit lane word from the bank
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module scanReader (
    input  logic                              ClockA,
    input  logic                              rstN,
    input  logic                              rdReq,
    input  logic [panelPkg::numBodyBits-1:0]  rdAddr,
    input  logic [panelPkg::laneWordBits-1:0] laneWord,
    output logic                              rdAck,
    output logic [panelPkg::laneWordBits-1:0] rdData,
    output logic                              fetchEnable,
    output logic [panelPkg::numBodyBits-1:0]  fetchAddr
);
    import panelPkg::*;

    readerState state;

    always_ff @(posedge ClockA or negedge rstN) begin
        if (!rstN) begin
            state       <= rdIdle;
            fetchEnable <= 1'b0;
            fetchAddr   <= '0;
            rdAck       <= 1'b0;
            rdData      <= '0;
        end else begin
            case (state)
                rdIdle: begin
                    // capture address, one-cycle fetch toward the RAMs
                    if (rdReq) begin
                        fetchAddr   <= rdAddr;
                        fetchEnable <= 1'b1;
                        state       <= rdFetch;
                    end
                end
                rdFetch: begin
                    if (fetchEnable) begin
                        // RAM output registers load on this edge
                        fetchEnable <= 1'b0;
                    end else begin
                        // lane word is settled now, latch it and ack
                        rdData <= laneWord;
                        rdAck  <= 1'b1;
                        state  <= rdHold;
                    end
                end
                rdHold: begin
                    // rdData stays put until the requester lets go
                    if (!rdReq) begin
                        rdAck <= 1'b0;
                        state <= rdIdle;
                    end
                end
                default: begin
                    state       <= rdIdle;
                    fetchEnable <= 1'b0;
                    rdAck       <= 1'b0;
                end
            endcase
        end
    end

    // fetch must stay inside its own phase, else the RAM output moves under rdData
    fetchInPhase: assert property (@(posedge ClockA) disable iff (!rstN)
        fetchEnable |-> state == rdFetch)
        else $error("scanReader: fetchEnable outside rdFetch");

endmodule

/* test/frameBufferTb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the panel frame buffer; plays the
// data file, then a random fill and full readback
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module frameBufferTb;
    timeunit 1ns;
    timeprecision 100ps;

    import panelPkg::*;

    // handshake waits give up after this many cycles
    localparam int maxWait = 20;
    localparam int numBodies = 1 << numBodyBits;

    // DUT ports
    logic                     ClockA;
    logic                     rstN;
    logic                     wrReq;
    logic                     wrAck;
    logic [numWrAddrBits-1:0] wrAddr;
    logic [dataBits-1:0]      wrData;
    logic                     rdReq;
    logic                     rdAck;
    logic [numBodyBits-1:0]   rdAddr;
    logic [laneWordBits-1:0]  rdData;

    // expected contents, one 64-bit lane word per body address
    logic [laneWordBits-1:0] model [0:numBodies-1];

    integer seed;
    integer checks;
    integer mismatches;
    integer failures;

    frameBuffer dut (
        .ClockA(ClockA),
        .rstN  (rstN),
        .wrReq (wrReq),
        .wrAck (wrAck),
        .wrAddr(wrAddr),
        .wrData(wrData),
        .rdReq (rdReq),
        .rdAck (rdAck),
        .rdAddr(rdAddr),
        .rdData(rdData)
    );

    // 100 ns period
    always #50 ClockA = ~ClockA;

    task automatic checkValue(input string name, input logic [laneWordBits-1:0] got,
                              input logic [laneWordBits-1:0] expected);
        checks++;
        if (got !== expected) begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, expected);
            mismatches++;
        end
    endtask

    // lane = {subpanel, colour select}, body is the middle field
    task automatic updateModel(input logic [numWrAddrBits-1:0] addr,
                               input logic [dataBits-1:0] data);
        logic [numLaneBits-1:0] lane;
        logic [numBodyBits-1:0] body;
        lane = {addr[numWrAddrBits-1], addr[numColorSelBits-1:0]};
        body = addr[numColorSelBits +: numBodyBits];
        // lane 0 is the low byte
        model[body][lane*dataBits +: dataBits] = data;
    endtask

    task automatic doWrite(input logic [numWrAddrBits-1:0] addr,
                           input logic [dataBits-1:0] data);
        integer edges;
        @(negedge ClockA);
        wrAddr = addr;
        wrData = data;
        wrReq  = 1'b1;
        // ack expected on the second rising edge after the request
        edges = 0;
        while (!wrAck && edges < maxWait) begin
            @(negedge ClockA);
            edges++;
        end
        if (!wrAck) begin
            $display("timeout: no wrAck for the write to address %h", addr);
            failures++;
        end else begin
            checkValue("wrAck rise edges", 64'(edges), 64'd2);
        end
        wrReq = 1'b0;
        // ack follows the request down on the next edge
        edges = 0;
        while (wrAck && edges < maxWait) begin
            @(negedge ClockA);
            edges++;
        end
        if (wrAck) begin
            $display("timeout: wrAck stayed high after wrReq was dropped");
            failures++;
        end else begin
            checkValue("wrAck fall edges", 64'(edges), 64'd1);
        end
        updateModel(addr, data);
    endtask

    task automatic doRead(input logic [numBodyBits-1:0] body,
                          input logic [laneWordBits-1:0] expected);
        integer edges;
        @(negedge ClockA);
        rdAddr = body;
        rdReq  = 1'b1;
        // fetch, RAM register, capture: three edges
        edges = 0;
        while (!rdAck && edges < maxWait) begin
            @(negedge ClockA);
            edges++;
        end
        if (!rdAck) begin
            $display("timeout: no rdAck for the read of body address %h", body);
            failures++;
        end else begin
            checkValue("rdAck rise edges", 64'(edges), 64'd3);
            checkValue("rdData", rdData, expected);
        end
        rdReq = 1'b0;
        edges = 0;
        while (rdAck && edges < maxWait) begin
            @(negedge ClockA);
            edges++;
        end
        if (rdAck) begin
            $display("timeout: rdAck stayed high after rdReq was dropped");
            failures++;
        end else begin
            checkValue("rdAck fall edges", 64'(edges), 64'd1);
        end
    endtask

    // directed lane mapping and isolation cases
    task automatic playTestFile();
        integer fd;
        integer code;
        integer done;
        logic [7:0]              op;
        logic [31:0]             addr;
        logic [laneWordBits-1:0] value;
        logic [8*128-1:0]        restOfLine;
        fd = $fopen("test/frameBufferTests.txt", "r");
        if (fd == 0) begin
            $display("could not open the test data file test/frameBufferTests.txt");
            failures++;
        end else begin
            done = 0;
            while (done == 0) begin
                code = $fscanf(fd, " %c", op);
                if (code != 1) begin
                    done = 1;
                end else if (op == "#") begin
                    // comment line, drop the rest of it
                    code = $fgets(restOfLine, fd);
                end else begin
                    code = $fscanf(fd, "%h %h", addr, value);
                    if (code != 2) begin
                        $display("malformed line in the test data file");
                        failures++;
                        done = 1;
                    end else if (op == "W") begin
                        doWrite(addr[numWrAddrBits-1:0], value[dataBits-1:0]);
                    end else if (op == "R") begin
                        // file word must also agree with the address layout
                        checkValue("file word vs model", model[addr[numBodyBits-1:0]], value);
                        doRead(addr[numBodyBits-1:0], value);
                    end else begin
                        $display("unknown opcode %c in the test data file", op);
                        failures++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // every byte address once, then every body address back
    task automatic fillAndReadBack();
        integer addr;
        integer body;
        logic [dataBits-1:0] value;
        for (addr = 0; addr < (1 << numWrAddrBits); addr++) begin
            value = 8'($random(seed));
            doWrite(addr[numWrAddrBits-1:0], value);
        end
        for (body = 0; body < numBodies; body++) begin
            doRead(body[numBodyBits-1:0], model[body]);
        end
    endtask

    initial begin
        integer i;
        seed       = 4872;
        checks     = 0;
        mismatches = 0;
        failures   = 0;
        ClockA = 1'b0;
        rstN   = 1'b0;
        wrReq  = 1'b0;
        wrAddr = '0;
        wrData = '0;
        rdReq  = 1'b0;
        rdAddr = '0;
        for (i = 0; i < numBodies; i++) begin
            model[i] = '0;
        end
        // reset for 3 cycles, released on a falling edge
        repeat (3) @(negedge ClockA);
        rstN = 1'b1;
        @(negedge ClockA);
        checkValue("wrAck after reset", 64'(wrAck), 64'd0);
        checkValue("rdAck after reset", 64'(rdAck), 64'd0);
        checkValue("rdData after reset", rdData, '0);
        playTestFile();
        fillAndReadBack();
        repeat (2) @(negedge ClockA);
        $display("summary: %0d checks, %0d mismatches, %0d other failures",
                 checks, mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* test/frameBufferTests.txt */
# columns: op addr value, all hex
# W: addr = {subpanel, body, colour select}, value = data byte
# R: addr = body, value = expected 64-bit word, lane 0 in the low byte
# body 0, all eight lanes
W 00 11
W 01 22
W 02 33
W 03 44
W 80 55
W 81 66
W 82 77
W 83 88
R 00 8877665544332211
# body 5
W 14 a0
W 15 a1
W 16 a2
W 17 a3
W 94 b0
W 95 b1
W 96 b2
W 97 b3
R 05 b3b2b1b0a3a2a1a0
# body 31, one bit per lane
W 7c 01
W 7d 02
W 7e 04
W 7f 08
W fc 10
W fd 20
W fe 40
W ff 80
R 1f 8040201008040201
# body 0 untouched by the other bodies
R 00 8877665544332211
# single byte overwrites, neighbours keep their values
W 82 ee
R 00 88ee665544332211
W 03 c3
R 00 88ee6655c3332211
W 15 5a
R 05 b3b2b1b0a3a25aa0
W ff 00
R 1f 0040201008040201
# other bodies still intact
R 05 b3b2b1b0a3a25aa0
R 00 88ee6655c3332211
